/* otp_lci_pkg.sv */
package otp_lci_pkg;

  ////////////////////
  // Word geometry
  ////////////////////

  // One native OTP word
  localparam int OtpWidth     = 16;
  // Words in the macro and the matching word address width
  localparam int OtpDepth     = 32;
  localparam int OtpAddrWidth = 5;

  ////////////////////
  // Life cycle field
  ////////////////////

  // Field is burned one native word at a time
  localparam int LcNumWords  = 4;
  localparam int LcDataWidth = LcNumWords * OtpWidth;
  // First word address of the field, so it covers words 8 to 11
  localparam int LcOffset    = 8;
  // Word counter inside the interface
  localparam int LcCntWidth  = $clog2(LcNumWords);
  localparam int LcLastWord  = LcNumWords - 1;

  ////////////////////
  // Macro timing
  ////////////////////

  // Cycles from the granted cycle to the response strobe
  localparam int OtpLatency     = 2;
  localparam int OtpLatCntWidth = $clog2(OtpLatency + 1);

  ////////////////////
  // Types
  ////////////////////

  // Macro command
  typedef enum logic {
    Read  = 1'b0,
    Write = 1'b1
  } otp_cmd_e;

  // Error codes returned by the macro and held by the interface
  typedef enum logic [1:0] {
    NoError              = 2'h0,
    MacroError           = 2'h1,
    MacroWriteBlankError = 2'h2,
    FsmStateError        = 2'h3
  } otp_err_e;

  // Life cycle interface FSM, only used inside otp_lci
  typedef enum logic [2:0] {
    ResetSt     = 3'h0,
    IdleSt      = 3'h1,
    WriteSt     = 3'h2,
    WriteWaitSt = 3'h3,
    ErrorSt     = 3'h4
  } lci_state_e;

endpackage

/* otp_lci.sv */
module otp_lci (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Enable level, leaves the reset state
  input  logic                                lci_en_i,
  // Escalation level, forces the terminal error state
  input  logic                                escalate_en_i,
  // Transition request, held until ack
  input  logic                                lc_req_i,
  input  logic [otp_lci_pkg::LcDataWidth-1:0] lc_data_i,
  output logic                                lc_ack_o,
  output logic                                lc_err_o,
  // Status
  output otp_lci_pkg::otp_err_e               error_o,
  output logic                                fsm_err_o,
  output logic                                lci_idle_o,
  // Macro request side
  output logic                                otp_req_o,
  output otp_lci_pkg::otp_cmd_e               otp_cmd_o,
  output logic [otp_lci_pkg::OtpAddrWidth-1:0] otp_addr_o,
  output logic [otp_lci_pkg::OtpWidth-1:0]    otp_wdata_o,
  input  logic                                otp_gnt_i,
  input  logic                                otp_rvalid_i,
  input  otp_lci_pkg::otp_err_e               otp_err_i
);

  import otp_lci_pkg::*;

  lci_state_e state_d, state_q;
  otp_err_e   error_d, error_q;

  // Word counter controls
  logic                  cnt_clr;
  logic                  cnt_en;
  logic [LcCntWidth-1:0] cnt_q;

  // Field viewed as an array of native words
  logic [LcNumWords-1:0][OtpWidth-1:0] lc_words;

  assign error_o = error_q;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d    = state_q;
    error_d    = error_q;
    cnt_clr    = 1'b0;
    cnt_en     = 1'b0;
    lci_idle_o = 1'b0;
    otp_req_o  = 1'b0;
    otp_cmd_o  = Read;
    lc_ack_o   = 1'b0;
    lc_err_o   = 1'b0;
    fsm_err_o  = 1'b0;

    unique case (state_q)
      // Hold off until the interface is enabled
      ResetSt: begin
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end
      // Ready for a transition request
      IdleSt: begin
        lci_idle_o = 1'b1;
        if (lc_req_i) begin
          state_d = WriteSt;
          cnt_clr = 1'b1;
        end
      end
      // Request the current word, stay here while the grant is withheld
      WriteSt: begin
        otp_req_o = 1'b1;
        otp_cmd_o = Write;
        if (otp_gnt_i) begin
          state_d = WriteWaitSt;
        end
      end
      // Wait for the macro response of the current word
      WriteWaitSt: begin
        if (otp_rvalid_i) begin
          // Latest nonzero code wins, remaining words are still burned
          if (otp_err_i != NoError) begin
            error_d = otp_err_i;
          end
          if (cnt_q == LcCntWidth'(LcLastWord)) begin
            lc_ack_o = 1'b1;
            state_d  = IdleSt;
            // Any collected error locks the interface
            if (error_d != NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end
          end else begin
            cnt_en  = 1'b1;
            state_d = WriteSt;
          end
        end
      end
      // Terminal, requests stay low
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
      // Invalid encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides everything from any state
    if (escalate_en_i) begin
      state_d = ErrorSt;
      if (error_d == NoError) begin
        error_d = FsmStateError;
      end
    end
  end

  ////////////////////
  // Address and data
  ////////////////////

  // Word address is the field offset plus the counter
  assign otp_addr_o = OtpAddrWidth'(LcOffset) + OtpAddrWidth'(cnt_q);

  assign lc_words = lc_data_i;
  // Only present data while a request is out
  assign otp_wdata_o = otp_req_o ? lc_words[cnt_q] : '0;

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
      if (cnt_clr) begin
        cnt_q <= '0;
      end else if (cnt_en) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

/* otp_arb.sv */
module otp_arb (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Life cycle interface requester
  input  logic                                 lci_req_i,
  input  otp_lci_pkg::otp_cmd_e                lci_cmd_i,
  input  logic [otp_lci_pkg::OtpAddrWidth-1:0] lci_addr_i,
  input  logic [otp_lci_pkg::OtpWidth-1:0]     lci_wdata_i,
  output logic                                 lci_gnt_o,
  output logic                                 lci_rvalid_o,
  output otp_lci_pkg::otp_err_e                lci_err_o,
  // External read port
  input  logic                                 rd_req_i,
  input  logic [otp_lci_pkg::OtpAddrWidth-1:0] rd_addr_i,
  output logic                                 rd_gnt_o,
  output logic                                 rd_valid_o,
  output logic [otp_lci_pkg::OtpWidth-1:0]     rd_data_o,
  output otp_lci_pkg::otp_err_e                rd_err_o,
  // Macro side
  output logic                                 otp_req_o,
  output otp_lci_pkg::otp_cmd_e                otp_cmd_o,
  output logic [otp_lci_pkg::OtpAddrWidth-1:0] otp_addr_o,
  output logic [otp_lci_pkg::OtpWidth-1:0]     otp_wdata_o,
  input  logic                                 otp_gnt_i,
  input  logic                                 otp_rvalid_i,
  input  logic [otp_lci_pkg::OtpWidth-1:0]     otp_rdata_i,
  input  otp_lci_pkg::otp_err_e                otp_err_i
);

  import otp_lci_pkg::*;

  // Read port has fixed priority
  logic sel_rd;
  // Owner of the outstanding command, high for the read port
  logic owner_rd_q;

  assign sel_rd = rd_req_i;

  ////////////////////
  // Request mux
  ////////////////////

  assign otp_req_o   = rd_req_i | lci_req_i;
  // Reads never carry write data
  assign otp_cmd_o   = sel_rd ? Read : lci_cmd_i;
  assign otp_addr_o  = sel_rd ? rd_addr_i : lci_addr_i;
  assign otp_wdata_o = sel_rd ? '0 : lci_wdata_i;

  // Grant only reaches the selected requester
  assign rd_gnt_o  = otp_gnt_i & sel_rd;
  assign lci_gnt_o = otp_gnt_i & ~sel_rd & lci_req_i;

  ////////////////////
  // Response steering
  ////////////////////

  assign rd_valid_o   = otp_rvalid_i & owner_rd_q;
  assign rd_data_o    = owner_rd_q ? otp_rdata_i : '0;
  assign rd_err_o     = owner_rd_q ? otp_err_i : NoError;
  assign lci_rvalid_o = otp_rvalid_i & ~owner_rd_q;
  assign lci_err_o    = owner_rd_q ? NoError : otp_err_i;

  // Owner is captured on grant and holds until the next one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_rd_q <= 1'b0;
    end else if (otp_gnt_i) begin
      owner_rd_q <= sel_rd;
    end
  end

endmodule

/* otp_macro_model.sv */
module otp_macro_model (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Command side
  input  logic                                 req_i,
  input  otp_lci_pkg::otp_cmd_e                cmd_i,
  input  logic [otp_lci_pkg::OtpAddrWidth-1:0] addr_i,
  input  logic [otp_lci_pkg::OtpWidth-1:0]     wdata_i,
  output logic                                 gnt_o,
  // Response side
  output logic                                 rvalid_o,
  output logic [otp_lci_pkg::OtpWidth-1:0]     rdata_o,
  output otp_lci_pkg::otp_err_e                err_o
);

  import otp_lci_pkg::*;

  // Fuse array
  logic [OtpWidth-1:0] mem_q [OtpDepth];

  // One command in flight
  logic                      pend_q;
  logic [OtpLatCntWidth-1:0] lat_cnt_q;

  // Response payload
  logic [OtpWidth-1:0] rdata_d, rdata_q;
  otp_err_e            err_d, err_q;

  // Command decode
  logic                addr_ok;
  logic                blank_fail;
  logic [OtpWidth-1:0] cur_word;

  ////////////////////
  // Handshake
  ////////////////////

  assign gnt_o    = req_i & ~pend_q;
  // Response leaves once the latency counter has run down
  assign rvalid_o = pend_q & (lat_cnt_q == '0);
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;

  ////////////////////
  // Command decode
  ////////////////////

  assign addr_ok  = int'(addr_i) < OtpDepth;
  assign cur_word = mem_q[addr_i];
  // A zero in the data where the fuse is already blown cannot be written
  assign blank_fail = |(cur_word & ~wdata_i);

  always_comb begin
    rdata_d = '0;
    err_d   = NoError;
    if (!addr_ok) begin
      err_d = MacroError;
    end else if (cmd_i == Read) begin
      rdata_d = cur_word;
    end else if (blank_fail) begin
      err_d = MacroWriteBlankError;
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q    <= 1'b0;
      lat_cnt_q <= '0;
      for (int i = 0; i < OtpDepth; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (gnt_o) begin
        pend_q    <= 1'b1;
        lat_cnt_q <= OtpLatCntWidth'(OtpLatency - 1);
        // Fuses only ever get set
        if (addr_ok && cmd_i == Write && !blank_fail) begin
          mem_q[addr_i] <= cur_word | wdata_i;
        end
      end else if (rvalid_o) begin
        pend_q <= 1'b0;
      end else if (pend_q) begin
        lat_cnt_q <= lat_cnt_q - 1'b1;
      end
    end
  end

  // Payload is captured at grant and held until the next one
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

endmodule

/* otp_lci_top.sv */
module otp_lci_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Life cycle side
  input  logic                                 lci_en_i,
  input  logic                                 escalate_en_i,
  input  logic                                 lc_req_i,
  input  logic [otp_lci_pkg::LcDataWidth-1:0]  lc_data_i,
  output logic                                 lc_ack_o,
  output logic                                 lc_err_o,
  output otp_lci_pkg::otp_err_e                error_o,
  output logic                                 fsm_err_o,
  output logic                                 lci_idle_o,
  // Read side
  input  logic                                 rd_req_i,
  input  logic [otp_lci_pkg::OtpAddrWidth-1:0] rd_addr_i,
  output logic                                 rd_gnt_o,
  output logic                                 rd_valid_o,
  output logic [otp_lci_pkg::OtpWidth-1:0]     rd_data_o,
  output otp_lci_pkg::otp_err_e                rd_err_o
);

  import otp_lci_pkg::*;

  // Interface to arbiter
  logic                    lci_req, lci_gnt, lci_rvalid;
  otp_cmd_e                lci_cmd;
  logic [OtpAddrWidth-1:0] lci_addr;
  logic [OtpWidth-1:0]     lci_wdata;
  otp_err_e                lci_err;

  // Arbiter to macro
  logic                    otp_req, otp_gnt, otp_rvalid;
  otp_cmd_e                otp_cmd;
  logic [OtpAddrWidth-1:0] otp_addr;
  logic [OtpWidth-1:0]     otp_wdata, otp_rdata;
  otp_err_e                otp_err;

  otp_lci i_lci (
    .clk_i, .rst_ni, .lci_en_i, .escalate_en_i, .lc_req_i, .lc_data_i,
    .lc_ack_o, .lc_err_o, .error_o, .fsm_err_o, .lci_idle_o,
    .otp_req_o(lci_req), .otp_cmd_o(lci_cmd), .otp_addr_o(lci_addr),
    .otp_wdata_o(lci_wdata), .otp_gnt_i(lci_gnt), .otp_rvalid_i(lci_rvalid),
    .otp_err_i(lci_err)
  );

  otp_arb i_arb (
    .clk_i, .rst_ni,
    .lci_req_i(lci_req), .lci_cmd_i(lci_cmd), .lci_addr_i(lci_addr),
    .lci_wdata_i(lci_wdata), .lci_gnt_o(lci_gnt), .lci_rvalid_o(lci_rvalid),
    .lci_err_o(lci_err),
    .rd_req_i, .rd_addr_i, .rd_gnt_o, .rd_valid_o, .rd_data_o, .rd_err_o,
    .otp_req_o(otp_req), .otp_cmd_o(otp_cmd), .otp_addr_o(otp_addr),
    .otp_wdata_o(otp_wdata), .otp_gnt_i(otp_gnt), .otp_rvalid_i(otp_rvalid),
    .otp_rdata_i(otp_rdata), .otp_err_i(otp_err)
  );

  otp_macro_model i_macro (
    .clk_i, .rst_ni,
    .req_i(otp_req), .cmd_i(otp_cmd), .addr_i(otp_addr), .wdata_i(otp_wdata),
    .gnt_o(otp_gnt), .rvalid_o(otp_rvalid), .rdata_o(otp_rdata), .err_o(otp_err)
  );

endmodule

/* tb_otp_lci.sv */
module tb_otp_lci;

  import otp_lci_pkg::*;

  // Input drive delay after the rising edge
  localparam int Drive        = 1;
  localparam int NumTrans     = 6;
  localparam int NumConcTrans = 2;
  localparam int NumConcReads = 6;
  localparam int NoAckWindow  = 24;
  // Watchdog budget from the length of the tests
  localparam int TotalTrans   = NumTrans + NumConcTrans + 6;
  localparam int TotalReads   = 2 * OtpDepth + NumConcTrans * (NumConcReads + LcNumWords)
                                + 2 * LcNumWords;
  localparam int WatchdogCycles = TotalTrans * 40 + TotalReads * 12 + 500;

  logic                    clk_i, rst_ni;
  logic                    lci_en_i, escalate_en_i, lc_req_i;
  logic [LcDataWidth-1:0]  lc_data_i;
  logic                    lc_ack_o, lc_err_o, fsm_err_o, lci_idle_o;
  otp_err_e                error_o;
  logic                    rd_req_i, rd_gnt_o, rd_valid_o;
  logic [OtpAddrWidth-1:0] rd_addr_i;
  logic [OtpWidth-1:0]     rd_data_o;
  otp_err_e                rd_err_o;

  // Model of the fuse array, and its state before the running transition
  logic [OtpWidth-1:0] model_mem [OtpDepth];
  logic [OtpWidth-1:0] old_mem [OtpDepth];
  otp_err_e            exp_error;
  integer              seed = 32'h5b431acb;
  int                  err_cnt = 0;
  int                  chk_cnt = 0;

  otp_lci_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input logic [OtpWidth-1:0] got,
                            input logic [OtpWidth-1:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("Fail: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_err(input string name, input otp_err_e got, input otp_err_e exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("Fail: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("Fail: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  ////////////////////
  // Model
  ////////////////////

  // OTP rule per word, a programmed bit that is missing in the data is a blank error
  function automatic otp_err_e predict_transition(input logic [LcDataWidth-1:0] data);
    otp_err_e            code;
    logic [OtpWidth-1:0] w;
    code = NoError;
    old_mem = model_mem;
    for (int i = 0; i < LcNumWords; i++) begin
      w = data[i*OtpWidth +: OtpWidth];
      if ((model_mem[LcOffset + i] & ~w) != '0) begin
        code = MacroWriteBlankError;
      end else begin
        model_mem[LcOffset + i] = model_mem[LcOffset + i] | w;
      end
    end
    return code;
  endfunction

  // Each word gains a few random bits on top of what is stored
  task automatic make_superset(output logic [LcDataWidth-1:0] data);
    logic [31:0] r1, r2;
    for (int i = 0; i < LcNumWords; i++) begin
      r1 = $random(seed);
      r2 = $random(seed);
      data[i*OtpWidth +: OtpWidth] = model_mem[LcOffset + i] | (r1[15:0] & r2[15:0]);
    end
  endtask

  ////////////////////
  // Bus tasks
  ////////////////////

  // All tasks start and end at the drive point after a rising edge
  task automatic run_transition(input logic [LcDataWidth-1:0] data);
    otp_err_e code;
    code = predict_transition(data);
    lc_data_i = data;
    lc_req_i  = 1'b1;
    @(negedge clk_i);
    while (!lc_ack_o) @(negedge clk_i);
    check_bit("lc_err_o", lc_err_o, code != NoError);
    @(posedge clk_i);
    #Drive;
    lc_req_i = 1'b0;
    // All words are burned once the ack is out
    old_mem = model_mem;
    if (code != NoError) begin
      exp_error = code;
    end
  endtask

  task automatic read_check(input logic [OtpAddrWidth-1:0] addr);
    logic [OtpWidth-1:0] exp_data;
    otp_err_e            exp_code;
    rd_addr_i = addr;
    rd_req_i  = 1'b1;
    @(negedge clk_i);
    while (!rd_gnt_o) @(negedge clk_i);
    @(posedge clk_i);
    #Drive;
    rd_req_i = 1'b0;
    @(negedge clk_i);
    while (!rd_valid_o) @(negedge clk_i);
    if (int'(addr) >= OtpDepth) begin
      exp_data = '0;
      exp_code = MacroError;
    end else begin
      // A word under a running transition may still hold its old value
      exp_data = (rd_data_o == old_mem[addr]) ? old_mem[addr] : model_mem[addr];
      exp_code = NoError;
    end
    check_word("rd_data_o", rd_data_o, exp_data);
    check_err("rd_err_o", rd_err_o, exp_code);
    @(posedge clk_i);
    #Drive;
  endtask

  task automatic read_field();
    for (int i = 0; i < LcNumWords; i++) begin
      read_check(OtpAddrWidth'(LcOffset + i));
    end
  endtask

  task automatic expect_no_ack(input logic [LcDataWidth-1:0] data, input int cycles);
    lc_data_i = data;
    lc_req_i  = 1'b1;
    repeat (cycles) begin
      @(negedge clk_i);
      if (lc_ack_o) begin
        $display("Error: a transition request was acknowledged although it must be ignored");
        err_cnt++;
      end
    end
    @(posedge clk_i);
    #Drive;
    lc_req_i = 1'b0;
  endtask

  task automatic apply_reset();
    rst_ni        = 1'b0;
    lci_en_i      = 1'b0;
    escalate_en_i = 1'b0;
    lc_req_i      = 1'b0;
    lc_data_i     = '0;
    rd_req_i      = 1'b0;
    rd_addr_i     = '0;
    repeat (4) @(posedge clk_i);
    #Drive;
    rst_ni = 1'b1;
    // Macro contents clear on reset
    for (int i = 0; i < OtpDepth; i++) begin
      model_mem[i] = '0;
    end
    old_mem   = model_mem;
    exp_error = NoError;
  endtask

  // Idle follows one cycle after enable
  task automatic enable_lci();
    lci_en_i = 1'b1;
    @(negedge clk_i);
    @(negedge clk_i);
    check_bit("lci_idle_o", lci_idle_o, 1'b1);
    check_bit("fsm_err_o", fsm_err_o, 1'b0);
    @(posedge clk_i);
    #Drive;
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    logic [LcDataWidth-1:0] data;
    logic [OtpWidth-1:0]    m;
    logic [31:0]            rnd;
    int                     k;
    apply_reset();

    // Disabled interface ignores requests
    @(negedge clk_i);
    check_bit("lci_idle_o", lci_idle_o, 1'b0);
    @(posedge clk_i);
    #Drive;
    make_superset(data);
    expect_no_ack(data, NoAckWindow);
    check_bit("lci_idle_o", lci_idle_o, 1'b0);
    enable_lci();

    // Growing transitions, then the whole array
    repeat (NumTrans) begin
      make_superset(data);
      run_transition(data);
      check_err("error_o", error_o, NoError);
    end
    for (int a = 0; a < OtpDepth; a++) begin
      read_check(OtpAddrWidth'(a));
    end
    check_err("error_o", error_o, NoError);

    // Reads compete with a running transition
    repeat (NumConcTrans) begin
      make_superset(data);
      fork
        run_transition(data);
        repeat (NumConcReads) begin
          rnd = $random(seed);
          repeat (rnd[1:0]) begin
            @(posedge clk_i);
            #Drive;
          end
          read_check(rnd[8:4]);
        end
      join
      check_err("error_o", error_o, NoError);
      read_field();
    end

    // Clear one programmed bit in one word
    make_superset(data);
    rnd = $random(seed);
    k = int'(rnd[1:0]);
    for (int n = 0; n < LcNumWords && model_mem[LcOffset + k] == '0; n++) begin
      k = (k + 1) % LcNumWords;
    end
    m = model_mem[LcOffset + k];
    data[k*OtpWidth +: OtpWidth] = m & (m - OtpWidth'(1));
    run_transition(data);
    check_err("error_o", error_o, exp_error);
    check_bit("lci_idle_o", lci_idle_o, 1'b0);
    read_field();
    make_superset(data);
    expect_no_ack(data, NoAckWindow);

    // Escalation in the middle of a transition
    apply_reset();
    enable_lci();
    make_superset(data);
    void'(predict_transition(data));
    lc_data_i = data;
    lc_req_i  = 1'b1;
    rnd = $random(seed);
    repeat (int'(rnd[2:0]) + 2) begin
      @(negedge clk_i);
      if (lc_ack_o) begin
        $display("Error: the transition finished before escalation was raised");
        err_cnt++;
      end
    end
    @(posedge clk_i);
    #Drive;
    escalate_en_i = 1'b1;
    @(negedge clk_i);
    @(negedge clk_i);
    check_err("error_o", error_o, FsmStateError);
    check_bit("lci_idle_o", lci_idle_o, 1'b0);
    @(posedge clk_i);
    #Drive;
    expect_no_ack(data, NoAckWindow);
    for (int a = 0; a < OtpDepth; a++) begin
      read_check(OtpAddrWidth'(a));
    end

    // Fresh run after reset
    apply_reset();
    enable_lci();
    make_superset(data);
    run_transition(data);
    check_err("error_o", error_o, NoError);
    read_field();

    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
otp_lci_pkg.sv
otp_lci.sv
otp_arb.sv
otp_macro_model.sv
otp_lci_top.sv
tb_otp_lci.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_otp_lci -f all.f -o sim_tb_otp_lci

output=$(./obj_dir/sim_tb_otp_lci)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
